/* nf_cfg.svh */
`ifndef NF_CFG_SVH
`define NF_CFG_SVH

// datapath width, also used for byte addresses
`define NF_XLEN         32

// general purpose registers, x0 included
`define NF_REG_NUM      32

// first fetch address after reset
`define NF_RESET_PC     32'h0000_0000

// one instruction word per fetch
`define NF_PC_STEP      32'd4

`endif

/* nf_isa_pkg.sv */
`default_nettype none

package nf_isa_pkg;

    typedef logic [31 : 0] instr_t;                 // raw rv32 instruction word
    typedef logic [2  : 0] funct3_t;                // instr[14:12]
    typedef logic [6  : 0] funct7_t;                // instr[31:25]

    // major opcodes of the kept subset, instr[6:0]
    typedef enum logic [6 : 0] {
        opc_op      = 7'b0110011,                   // add sub and or xor sll srl
        opc_op_imm  = 7'b0010011,                   // addi
        opc_lui     = 7'b0110111,                   // lui
        opc_store   = 7'b0100011,                   // sw
        opc_system  = 7'b1110011                    // ecall
    } opcode_e;

    typedef enum funct3_t {
        f3_add  = 3'b000,                           // add, sub, addi
        f3_sll  = 3'b001,
        f3_sw   = 3'b010,                           // word store size
        f3_xor  = 3'b100,
        f3_srl  = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } funct3_e;

    typedef enum funct7_t {
        f7_base = 7'b0000000,
        f7_alt  = 7'b0100000                        // selects sub (and sra, not kept)
    } funct7_e;

    localparam instr_t nop_instr = 32'h0000_0013;   // addi x0, x0, 0

endpackage : nf_isa_pkg

`default_nettype wire

/* nf_pipe_pkg.sv */
`default_nettype none

`include "nf_cfg.svh"

package nf_pipe_pkg;

    typedef logic [`NF_XLEN-1 : 0]              data_t;     // register and alu word
    typedef logic [`NF_XLEN-1 : 0]              addr_t;     // byte address
    typedef logic [$clog2(`NF_REG_NUM)-1 : 0]   reg_addr_t; // register index

    // alu operations, pass_b serves lui
    typedef enum logic [3 : 0] {
        alu_add     = 4'd0,
        alu_sub     = 4'd1,
        alu_and     = 4'd2,
        alu_or      = 4'd3,
        alu_xor     = 4'd4,
        alu_sll     = 4'd5,
        alu_srl     = 4'd6,
        alu_pass_b  = 4'd7
    } alu_op_e;

    // fetch fsm
    typedef enum logic [1 : 0] {
        st_idle     = 2'b00,                        // leaving reset
        st_fetch    = 2'b01,                        // request held high
        st_halt     = 2'b10                         // ecall seen, no more requests
    } fetch_state_e;

endpackage : nf_pipe_pkg

`default_nettype wire

/* nf_fetch_unit.sv */
`default_nettype none
`timescale 1ns/10ps

`include "nf_cfg.svh"

module nf_fetch_unit (
    input  logic                clk_i,          // core clock
    input  logic                arst_n_i,       // async reset, active low
    input  nf_isa_pkg::instr_t  imem_rd_i,      // word from instruction memory
    input  logic                imem_ack_i,     // word valid in this cycle
    output nf_pipe_pkg::addr_t  imem_addr_o,    // fetch address
    output logic                imem_req_o,     // request level
    output nf_isa_pkg::instr_t  instr_o,        // instruction for decode
    output logic                halted_o        // ecall reached
);

    import nf_isa_pkg::*;
    import nf_pipe_pkg::*;

    fetch_state_e   state;                      // current fsm state
    fetch_state_e   state_nxt;                  // next fsm state
    addr_t          pc;                         // address of the word being requested
    logic           take;                       // word accepted at this edge
    logic           is_ecall;                   // accepted word is a system opcode

    assign imem_req_o  = (state == st_fetch);
    assign imem_addr_o = pc;
    assign halted_o    = (state == st_halt);
    assign take        = imem_req_o & imem_ack_i;
    assign is_ecall    = (imem_rd_i[6 : 0] == opc_system);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                state_nxt = st_fetch;           // one idle cycle after reset release
            end
            st_fetch: begin
                if (take && is_ecall) begin
                    state_nxt = st_halt;
                end
            end
            st_halt: begin
                state_nxt = st_halt;            // only reset leaves halt
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // the pc only moves on an accepted word; ecall and missing ack give a bubble
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= st_idle;
            pc      <= `NF_RESET_PC;
            instr_o <= nop_instr;
        end else begin
            state <= state_nxt;
            if (take && !is_ecall) begin
                pc      <= pc + `NF_PC_STEP;    // next word
                instr_o <= imem_rd_i;           // word enters decode
            end else begin
                instr_o <= nop_instr;           // bubble into decode
            end
        end
    end

endmodule : nf_fetch_unit

`default_nettype wire

/* nf_decode_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module nf_decode_unit (
    input  nf_isa_pkg::instr_t      instr_i,        // instruction in decode
    output nf_pipe_pkg::reg_addr_t  ra1_o,          // rs1 index
    output nf_pipe_pkg::reg_addr_t  ra2_o,          // rs2 index
    output nf_pipe_pkg::reg_addr_t  wa_o,           // rd index
    output nf_pipe_pkg::data_t      imm_o,          // extended immediate
    output logic                    b_imm_sel_o,    // operand b from immediate
    output nf_pipe_pkg::alu_op_e    alu_op_o,       // alu operation
    output logic                    we_rf_o,        // register write
    output logic                    we_dm_o         // data store
);

    import nf_isa_pkg::*;
    import nf_pipe_pkg::*;

    opcode_e    opcode;                             // instr[6:0]
    funct3_e    funct3;                             // instr[14:12]
    funct7_e    funct7;                             // instr[31:25]
    data_t      imm_i;                              // i-format, addi
    data_t      imm_s;                              // s-format, sw offset
    data_t      imm_u;                              // u-format, lui

    assign opcode = opcode_e'(instr_i[6 : 0]);
    assign funct3 = funct3_e'(instr_i[14 : 12]);
    assign funct7 = funct7_e'(instr_i[31 : 25]);

    assign ra1_o  = instr_i[19 : 15];
    assign ra2_o  = instr_i[24 : 20];              // also sw data register
    assign wa_o   = instr_i[11 : 7];

    assign imm_i  = {{20{instr_i[31]}}, instr_i[31 : 20]};
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31 : 25], instr_i[11 : 7]};
    assign imm_u  = {instr_i[31 : 12], 12'b0};

    always_comb begin
        imm_o       = '0;
        b_imm_sel_o = 1'b0;
        alu_op_o    = alu_add;
        we_rf_o     = 1'b0;                         // unknown words change nothing
        we_dm_o     = 1'b0;
        case (opcode)
            opc_op: begin
                we_rf_o = 1'b1;
                case (funct3)
                    f3_add:  alu_op_o = (funct7 == f7_alt) ? alu_sub : alu_add;
                    f3_sll:  alu_op_o = alu_sll;
                    f3_xor:  alu_op_o = alu_xor;
                    f3_srl:  alu_op_o = alu_srl;
                    f3_or:   alu_op_o = alu_or;
                    f3_and:  alu_op_o = alu_and;
                    default: we_rf_o  = 1'b0;       // slt, sltu
                endcase
                if ((funct3 == f3_srl) && (funct7 == f7_alt)) begin
                    we_rf_o = 1'b0;                 // sra is outside the subset
                end
            end
            opc_op_imm: begin
                imm_o       = imm_i;
                b_imm_sel_o = 1'b1;
                we_rf_o     = (funct3 == f3_add);   // addi only
            end
            opc_lui: begin
                imm_o       = imm_u;
                b_imm_sel_o = 1'b1;
                alu_op_o    = alu_pass_b;
                we_rf_o     = 1'b1;
            end
            opc_store: begin
                imm_o       = imm_s;                // address is rs1 + offset
                b_imm_sel_o = 1'b1;
                we_dm_o     = (funct3 == f3_sw);    // word stores only
            end
            default: begin
            end
        endcase
    end

endmodule : nf_decode_unit

`default_nettype wire

/* nf_reg_file.sv */
`default_nettype none
`timescale 1ns/10ps

`include "nf_cfg.svh"

module nf_reg_file (
    input  logic                    clk_i,      // core clock
    input  nf_pipe_pkg::reg_addr_t  ra1_i,      // read index, port 1
    input  nf_pipe_pkg::reg_addr_t  ra2_i,      // read index, port 2
    input  nf_pipe_pkg::reg_addr_t  wa_i,       // write index
    input  nf_pipe_pkg::data_t      wd_i,       // write data
    input  logic                    we_i,       // write enable
    output nf_pipe_pkg::data_t      rd1_o,      // read data, port 1
    output nf_pipe_pkg::data_t      rd2_o       // read data, port 2
);

    import nf_pipe_pkg::*;

    data_t regs [`NF_REG_NUM];                  // x0 entry is never written

    always_ff @(posedge clk_i) begin
        if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    // write-first read covers a producer three instructions ahead
    assign rd1_o = (ra1_i == '0)              ? '0   :
                   (we_i && (ra1_i == wa_i))  ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0)              ? '0   :
                   (we_i && (ra2_i == wa_i))  ? wd_i : regs[ra2_i];

endmodule : nf_reg_file

`default_nettype wire

/* nf_exec_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module nf_exec_unit (
    input  nf_pipe_pkg::data_t      op1_i,          // bypassed rs1 value
    input  nf_pipe_pkg::data_t      op2_i,          // bypassed rs2 value
    input  nf_pipe_pkg::data_t      imm_i,          // extended immediate
    input  logic                    b_imm_sel_i,    // operand b from immediate
    input  nf_pipe_pkg::alu_op_e    alu_op_i,       // operation code
    output nf_pipe_pkg::data_t      result_o        // alu result or store address
);

    import nf_pipe_pkg::*;

    data_t  op_b;                                   // selected second operand
    logic   [4 : 0] shamt;                          // shift amount

    assign op_b  = b_imm_sel_i ? imm_i : op2_i;
    assign shamt = op_b[4 : 0];

    always_comb begin
        case (alu_op_i)
            alu_add:    result_o = op1_i + op_b;
            alu_sub:    result_o = op1_i - op_b;
            alu_and:    result_o = op1_i & op_b;
            alu_or:     result_o = op1_i | op_b;
            alu_xor:    result_o = op1_i ^ op_b;
            alu_sll:    result_o = op1_i << shamt;
            alu_srl:    result_o = op1_i >> shamt;  // logical, zero fill
            alu_pass_b: result_o = op_b;            // lui
            default:    result_o = op1_i + op_b;
        endcase
    end

endmodule : nf_exec_unit

`default_nettype wire

/* nf_bypass_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module nf_bypass_unit (
    input  nf_pipe_pkg::reg_addr_t  ra1_i,          // rs1 index in execute
    input  nf_pipe_pkg::reg_addr_t  ra2_i,          // rs2 index in execute
    input  nf_pipe_pkg::data_t      rd1_i,          // rs1 copy from stage register
    input  nf_pipe_pkg::data_t      rd2_i,          // rs2 copy from stage register
    input  nf_pipe_pkg::reg_addr_t  wa_mem_i,       // destination in memory stage
    input  logic                    we_rf_mem_i,    // memory stage writes a register
    input  nf_pipe_pkg::data_t      result_mem_i,   // memory stage result
    input  nf_pipe_pkg::reg_addr_t  wa_wb_i,        // destination in write-back
    input  logic                    we_rf_wb_i,     // write-back writes a register
    input  nf_pipe_pkg::data_t      wd_wb_i,        // write-back data
    output nf_pipe_pkg::data_t      op1_o,          // operand 1 for alu
    output nf_pipe_pkg::data_t      op2_o           // operand 2 for alu and store data
);

    import nf_pipe_pkg::*;

    // newest producer wins, x0 is never forwarded
    function automatic data_t pick(input reg_addr_t ra, input data_t rd,
                                   input reg_addr_t wa_mem, input logic we_mem,
                                   input data_t res_mem, input reg_addr_t wa_wb,
                                   input logic we_wb, input data_t wd_wb);
        data_t sel;
        if ((ra != '0) && we_mem && (wa_mem == ra)) begin
            sel = res_mem;                          // distance 1
        end else if ((ra != '0) && we_wb && (wa_wb == ra)) begin
            sel = wd_wb;                            // distance 2
        end else begin
            sel = rd;
        end
        return sel;
    endfunction

    assign op1_o = pick(ra1_i, rd1_i, wa_mem_i, we_rf_mem_i, result_mem_i,
                        wa_wb_i, we_rf_wb_i, wd_wb_i);
    assign op2_o = pick(ra2_i, rd2_i, wa_mem_i, we_rf_mem_i, result_mem_i,
                        wa_wb_i, we_rf_wb_i, wd_wb_i);

endmodule : nf_bypass_unit

`default_nettype wire

/* nf_cpu.sv */
`default_nettype none
`timescale 1ns/10ps

module nf_cpu (
    input  logic                clk_i,          // core clock
    input  logic                arst_n_i,       // async reset, active low
    input  nf_isa_pkg::instr_t  imem_rd_i,      // instruction memory read data
    input  logic                imem_ack_i,     // instruction memory acknowledge
    output nf_pipe_pkg::addr_t  imem_addr_o,    // instruction memory address
    output logic                imem_req_o,     // instruction memory request
    output logic                halted_o,       // ecall reached
    output nf_pipe_pkg::addr_t  dmem_addr_o,    // store address
    output nf_pipe_pkg::data_t  dmem_wd_o,      // store data
    output logic                dmem_we_o       // one-cycle store strobe
);

    import nf_isa_pkg::*;
    import nf_pipe_pkg::*;

    instr_t     instr_id;                       // decode stage
    reg_addr_t  ra1_id, ra2_id, wa_id;
    data_t      imm_id, rd1_id, rd2_id;
    logic       b_imm_sel_id, we_rf_id, we_dm_id;
    alu_op_e    alu_op_id;

    reg_addr_t  ra1_ex, ra2_ex, wa_ex;          // execute stage
    data_t      imm_ex, rd1_ex, rd2_ex;
    data_t      op1_ex, op2_ex, result_ex;
    logic       b_imm_sel_ex, we_rf_ex, we_dm_ex;
    alu_op_e    alu_op_ex;

    data_t      result_mem, sd_mem;             // memory stage
    reg_addr_t  wa_mem;
    logic       we_rf_mem, we_dm_mem;

    data_t      result_wb;                      // write-back stage
    reg_addr_t  wa_wb;
    logic       we_rf_wb;

    nf_fetch_unit u_fetch (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .imem_rd_i   (imem_rd_i),
        .imem_ack_i  (imem_ack_i),
        .imem_addr_o (imem_addr_o),
        .imem_req_o  (imem_req_o),
        .instr_o     (instr_id),                // fetch register feeds decode directly
        .halted_o    (halted_o)
    );

    nf_decode_unit u_decode (
        .instr_i     (instr_id),
        .ra1_o       (ra1_id),
        .ra2_o       (ra2_id),
        .wa_o        (wa_id),
        .imm_o       (imm_id),
        .b_imm_sel_o (b_imm_sel_id),
        .alu_op_o    (alu_op_id),
        .we_rf_o     (we_rf_id),
        .we_dm_o     (we_dm_id)
    );

    nf_reg_file u_reg_file (
        .clk_i (clk_i),
        .ra1_i (ra1_id),                        // read in decode
        .ra2_i (ra2_id),
        .wa_i  (wa_wb),                         // written from write-back
        .wd_i  (result_wb),
        .we_i  (we_rf_wb),
        .rd1_o (rd1_id),
        .rd2_o (rd2_id)
    );

    // control flags of every stage clear on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            we_rf_ex  <= 1'b0;
            we_dm_ex  <= 1'b0;
            we_rf_mem <= 1'b0;
            we_dm_mem <= 1'b0;
            we_rf_wb  <= 1'b0;
        end else begin
            we_rf_ex  <= we_rf_id;
            we_dm_ex  <= we_dm_id;
            we_rf_mem <= we_rf_ex;
            we_dm_mem <= we_dm_ex;
            we_rf_wb  <= we_rf_mem;
        end
    end

    always_ff @(posedge clk_i) begin
        ra1_ex       <= ra1_id;                 // id to ex
        ra2_ex       <= ra2_id;
        wa_ex        <= wa_id;
        rd1_ex       <= rd1_id;
        rd2_ex       <= rd2_id;
        imm_ex       <= imm_id;
        b_imm_sel_ex <= b_imm_sel_id;
        alu_op_ex    <= alu_op_id;
        result_mem   <= result_ex;              // ex to mem
        sd_mem       <= op2_ex;                 // bypassed rs2 is the sw data
        wa_mem       <= wa_ex;
        result_wb    <= result_mem;             // mem to wb
        wa_wb        <= wa_mem;
    end

    nf_bypass_unit u_bypass (
        .ra1_i        (ra1_ex),
        .ra2_i        (ra2_ex),
        .rd1_i        (rd1_ex),
        .rd2_i        (rd2_ex),
        .wa_mem_i     (wa_mem),
        .we_rf_mem_i  (we_rf_mem),
        .result_mem_i (result_mem),
        .wa_wb_i      (wa_wb),
        .we_rf_wb_i   (we_rf_wb),
        .wd_wb_i      (result_wb),
        .op1_o        (op1_ex),
        .op2_o        (op2_ex)
    );

    nf_exec_unit u_exec (
        .op1_i       (op1_ex),
        .op2_i       (op2_ex),
        .imm_i       (imm_ex),
        .b_imm_sel_i (b_imm_sel_ex),
        .alu_op_i    (alu_op_ex),
        .result_o    (result_ex)
    );

    assign dmem_we_o   = we_dm_mem;             // high for the one cycle sw sits in mem
    assign dmem_addr_o = result_mem;
    assign dmem_wd_o   = sd_mem;

endmodule : nf_cpu

`default_nettype wire

/* nf_cpu_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module nf_cpu_tb;

    localparam int unsigned CLK_PERIOD    = 8;              // ns
    localparam int unsigned RESET_CYCLES  = 8;
    localparam int unsigned HALT_TIMEOUT  = 400;            // cycles until halted_o
    localparam int unsigned DRAIN_CYCLES  = 4;              // pipeline empties within 3
    localparam int unsigned PROG_LEN      = 33;
    localparam int unsigned STORE_NUM     = 14;
    localparam logic [31:0] LCG_SEED      = 32'h4971ecc6;
    localparam logic [31:0] ACK_THRESHOLD = 32'hA000_0000;  // ack when lcg value is below
    localparam logic [6:0]  F7_BASE       = 7'b0000000;
    localparam logic [6:0]  F7_ALT        = 7'b0100000;     // sub
    localparam logic [31:0] ECALL_WORD    = 32'h0000_0073;

    logic        clk_i = 1'b0;                              // low from the first instant
    logic        arst_n_i;
    logic [31:0] imem_rd_i;
    logic        imem_ack_i;
    logic [31:0] imem_addr_o;
    logic        imem_req_o;
    logic        halted_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wd_o;
    logic        dmem_we_o;

    logic [31:0] prog      [PROG_LEN];                      // program words
    logic [63:0] exp_store [STORE_NUM];                     // {address, data} in order
    int unsigned errors;
    int unsigned checks;
    int unsigned store_idx;                                 // next expected store
    logic [31:0] exp_pc;                                    // next expected fetch address
    logic [31:0] lcg_state;
    logic        gap_mode;                                  // random ack gaps on

    nf_cpu dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .imem_rd_i   (imem_rd_i),
        .imem_ack_i  (imem_ack_i),
        .imem_addr_o (imem_addr_o),
        .imem_req_o  (imem_req_o),
        .halted_o    (halted_o),
        .dmem_addr_o (dmem_addr_o),
        .dmem_wd_o   (dmem_wd_o),
        .dmem_we_o   (dmem_we_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rv32 encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};                  // addi
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};                               // lui
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:2] < PROG_LEN) begin
            return prog[addr[31:2]];
        end
        return ECALL_WORD;                                          // ecall past the end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic load_tables();
        logic [4:0] store_src [10];
        store_src = '{5'd1, 5'd2, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11, 5'd0};
        prog[0]  = enc_u(20'h12345, 5'd1);                          // x1 = 0x12345000
        prog[1]  = enc_i(12'hFFB, 5'd0, 5'd2);                      // x2 = -5
        prog[2]  = enc_i(12'h0F0, 5'd0, 5'd3);                      // x3 = 0xf0
        prog[3]  = enc_i(12'h004, 5'd0, 5'd4);                      // x4 = 4
        prog[4]  = enc_r(F7_BASE, 5'd2, 5'd1, 3'b000, 5'd5);        // add x5, x1, x2
        prog[5]  = enc_r(F7_ALT, 5'd2, 5'd3, 3'b000, 5'd6);         // sub x6, x3, x2
        prog[6]  = enc_r(F7_BASE, 5'd3, 5'd2, 3'b111, 5'd7);        // and x7, x2, x3
        prog[7]  = enc_r(F7_BASE, 5'd3, 5'd1, 3'b110, 5'd8);        // or x8, x1, x3
        prog[8]  = enc_r(F7_BASE, 5'd3, 5'd2, 3'b100, 5'd9);        // xor x9, x2, x3
        prog[9]  = enc_r(F7_BASE, 5'd4, 5'd3, 3'b001, 5'd10);       // sll x10, x3, x4
        prog[10] = enc_r(F7_BASE, 5'd4, 5'd2, 3'b101, 5'd11);       // srl x11, x2, x4
        prog[11] = enc_i(12'h007, 5'd0, 5'd0);                      // write to x0 is lost
        for (int i = 0; i < 10; i++) begin
            prog[12 + i] = enc_s(12'(i * 4), store_src[i], 5'd0);   // sw at 0..36
        end
        prog[22] = enc_i(12'd100, 5'd0, 5'd12);                     // x12 = 100
        prog[23] = enc_r(F7_BASE, 5'd12, 5'd12, 3'b000, 5'd13);     // x13 = 200 at distance 1
        prog[24] = enc_i(12'd0, 5'd0, 5'd0);                        // nop
        prog[25] = enc_r(F7_BASE, 5'd12, 5'd13, 3'b000, 5'd14);     // distances 2 and 3
        prog[26] = enc_r(F7_ALT, 5'd12, 5'd14, 3'b000, 5'd15);      // x15 = 200 at distance 1
        prog[27] = enc_s(12'd40, 5'd15, 5'd0);                      // store data bypassed
        prog[28] = enc_s(12'd44, 5'd14, 5'd0);                      // distance 3
        prog[29] = enc_s(12'd48, 5'd13, 5'd0);                      // independent copy
        prog[30] = enc_i(12'd64, 5'd0, 5'd16);                      // x16 = 64
        prog[31] = enc_s(12'd0, 5'd12, 5'd16);                      // base bypassed
        prog[32] = ECALL_WORD;
        exp_store[0]  = {32'h0000_0000, 32'h1234_5000};            // lui
        exp_store[1]  = {32'h0000_0004, 32'hFFFF_FFFB};            // addi negative
        exp_store[2]  = {32'h0000_0008, 32'h1234_4FFB};            // add
        exp_store[3]  = {32'h0000_000C, 32'h0000_00F5};            // sub
        exp_store[4]  = {32'h0000_0010, 32'h0000_00F0};            // and
        exp_store[5]  = {32'h0000_0014, 32'h1234_50F0};            // or
        exp_store[6]  = {32'h0000_0018, 32'hFFFF_FF0B};            // xor
        exp_store[7]  = {32'h0000_001C, 32'h0000_0F00};            // sll
        exp_store[8]  = {32'h0000_0020, 32'h0FFF_FFFF};            // srl zero fill
        exp_store[9]  = {32'h0000_0024, 32'h0000_0000};            // x0
        exp_store[10] = {32'h0000_0028, 32'h0000_00C8};
        exp_store[11] = {32'h0000_002C, 32'h0000_012C};
        exp_store[12] = {32'h0000_0030, 32'h0000_00C8};
        exp_store[13] = {32'h0000_0040, 32'h0000_0064};
    endtask

    // instruction memory model answers 1 ns after the edge
    always @(posedge clk_i) begin
        #1;
        lcg_state = lcg_next(lcg_state);
        if (!imem_req_o) begin
            imem_ack_i = 1'b0;
        end else if (gap_mode) begin
            imem_ack_i = (lcg_state < ACK_THRESHOLD);
        end else begin
            imem_ack_i = 1'b1;
        end
        imem_rd_i = fetch_word(imem_addr_o);
    end

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            check_value("imem_req_o", imem_req_o, 1'b0);
            check_value("dmem_we_o", dmem_we_o, 1'b0);
            check_value("halted_o", halted_o, 1'b0);
        end else begin
            if (imem_req_o) begin
                check_value("imem_addr_o", imem_addr_o, exp_pc);
                if (imem_ack_i) begin
                    exp_pc = exp_pc + 32'd4;                        // accepted word moves on
                end
            end
            if (halted_o) begin
                check_value("imem_req_o", imem_req_o, 1'b0);
            end
            if (dmem_we_o) begin
                if (store_idx < STORE_NUM) begin
                    check_value("dmem_addr_o", dmem_addr_o, exp_store[store_idx][63:32]);
                    check_value("dmem_wd_o", dmem_wd_o, exp_store[store_idx][31:0]);
                end else begin
                    $display("unexpected store at %0t to address %h after the expected list",
                             $time, dmem_addr_o);
                    errors++;
                end
                store_idx++;
            end
        end
    end

    task automatic run_program(input logic with_gaps);
        int unsigned cycles;
        @(posedge clk_i);
        #1;
        arst_n_i  = 1'b0;
        gap_mode  = with_gaps;
        store_idx = 0;
        exp_pc    = 32'h0;                                      // first request at reset pc
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("imem_req_o", imem_req_o, 1'b0);            // still idle
        check_value("dmem_we_o", dmem_we_o, 1'b0);
        cycles = 0;
        while (!halted_o && (cycles < HALT_TIMEOUT)) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!halted_o) begin
            $display("timeout at %0t: halted_o did not rise within %0d cycles",
                     $time, HALT_TIMEOUT);
            errors++;
        end
        repeat (DRAIN_CYCLES) @(negedge clk_i);
        if (store_idx != STORE_NUM) begin
            $display("store count is %0d, expected %0d (gaps %0b)",
                     store_idx, STORE_NUM, with_gaps);
            errors++;
        end
    endtask

    initial begin
        arst_n_i   = 1'b0;
        imem_rd_i  = 32'h0;
        imem_ack_i = 1'b0;
        errors     = 0;
        checks     = 0;
        store_idx  = 0;
        exp_pc     = 32'h0;
        gap_mode   = 1'b0;
        lcg_state  = LCG_SEED;
        load_tables();
        run_program(1'b0);                                      // ack always high
        run_program(1'b1);                                      // random ack gaps
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : nf_cpu_tb

`default_nettype wire

/* tb.f */
+incdir+.
nf_isa_pkg.sv
nf_pipe_pkg.sv
nf_fetch_unit.sv
nf_decode_unit.sv
nf_reg_file.sv
nf_exec_unit.sv
nf_bypass_unit.sv
nf_cpu.sv
nf_cpu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= tb.f
TB_TOP     ?= nf_cpu_tb
RTL_TOP    ?= nf_cpu
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
